//--- sim.f
+incdir+hdl
hdl/rv_pipe_pkg.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/hazard_ctrl.sv
hdl/rv_pipe_top.sv
tb/rv_pipe_tb.sv

//--- Makefile
TOP := rv_pipe_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP) -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

//--- tb/rv_pipe_tb.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module rv_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  localparam int DRAIN_CYCLES   = 12;
  localparam int MAX_RETIRE     = 48;   // per program
  localparam int CYC_PER_COMMIT = 8;    // covers fetch gaps and flushes
  localparam int RUNS           = 7;
  localparam int WATCHDOG_NS    = RUNS * CLK_PERIOD *
                                  (RESET_CYCLES + DRAIN_CYCLES + MAX_RETIRE * CYC_PER_COMMIT + 32);

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic [`XLEN-1:0]   data;
  } commit_t;

  logic               clk = 1'b0;
  logic               rst_i = 1'b1;
  logic [`XLEN-1:0]   imem_addr_o;
  logic               imem_req_o;
  logic [`XLEN-1:0]   imem_data_i;
  logic               imem_valid_i;
  logic               commit_valid_o;
  logic [`XLEN-1:0]   commit_pc_o;
  logic [`REG_AW-1:0] commit_rd_o;
  logic               commit_we_o;
  logic [`XLEN-1:0]   commit_data_o;

  logic [31:0] prog [64];
  logic [31:0] prog_len;
  logic        in_prog;
  logic        gaps_on;
  logic        gap_ok;
  logic [31:0] lfsr;
  commit_t     exp_q [$];
  commit_t     got;
  int          retired;
  int          expected;
  string       test_name;

  rv_pipe_top dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .imem_addr_o    (imem_addr_o),
    .imem_req_o     (imem_req_o),
    .imem_data_i    (imem_data_i),
    .imem_valid_i   (imem_valid_i),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_rd_o    (commit_rd_o),
    .commit_we_o    (commit_we_o),
    .commit_data_o  (commit_data_o)
  );

  initial forever #(CLK_PERIOD / 2) clk = ~clk;

  // instruction memory, answers in the same cycle
  assign in_prog      = (imem_addr_o >> 2) < prog_len;
  assign imem_valid_i = in_prog && imem_req_o && gap_ok;
  assign imem_data_i  = in_prog ? prog[imem_addr_o[7:2]]
                                : imem_addr_o ^ 32'h5a5a_5a5a;  // never valid out here

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  // wait states: valid drops when two lfsr bits are both set
  always @(posedge clk) begin
    logic b0;
    logic b1;
    #1;
    if (gaps_on) begin
      b0     = lfsr[0];
      lfsr   = lfsr_next(lfsr);
      b1     = lfsr[0];
      lfsr   = lfsr_next(lfsr);
      gap_ok = !(b0 && b1);
    end else begin
      gap_ok = 1'b1;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_val(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      fail_now($sformatf("Error %s: %s expected %h, actual %h", test_name, what, exp_v, act_v));
    end
  endtask

  // retire monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_i && commit_valid_o) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("%s: pc %h retired with nothing left to retire",
                           test_name, commit_pc_o));
      end else begin
        got = exp_q.pop_front();
        check_val("commit pc", got.pc, commit_pc_o);
        check_val("commit we", 32'(got.we), 32'(commit_we_o));
        if (got.we) begin
          check_val("commit rd", 32'(got.rd), 32'(commit_rd_o));
          check_val("commit data", got.data, commit_data_o);
        end
        retired++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now("watchdog expired before all tests finished");
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  task automatic add_instr(input logic [31:0] w);
    prog[prog_len[5:0]] = w;
    prog_len            = prog_len + 32'd1;
  endtask

  // architectural model, walks the program until pc leaves it
  task automatic run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [31:0] i_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [2:0]  f3;
    logic        we;
    commit_t     c;
    int          steps;
    regs = '{default: '0};
    pc = `RESET_PC;
    steps = 0;
    exp_q.delete();
    while ((pc >> 2) < prog_len) begin
      w     = prog[pc[7:2]];
      f3    = w[14:12];
      a     = regs[w[19:15]];
      b     = regs[w[24:20]];
      i_imm = {{20{w[31]}}, w[31:20]};
      b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      we    = 1'b0;
      res   = '0;
      nxt   = pc + 32'd4;
      case (w[6:0])
        `OPC_OP: begin
          we = 1'b1;
          case (f3)
            3'd0:    res = w[30] ? a - b : a + b;
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd6:    res = a | b;
            3'd7:    res = a & b;
            default: we = 1'b0;
          endcase
        end
        `OPC_OP_IMM: begin
          we = 1'b1;
          case (f3)
            3'd0:    res = a + i_imm;
            3'd4:    res = a ^ i_imm;
            3'd6:    res = a | i_imm;
            3'd7:    res = a & i_imm;
            default: we = 1'b0;
          endcase
        end
        `OPC_LUI: begin
          we  = 1'b1;
          res = {w[31:12], 12'h000};
        end
        `OPC_BRANCH: begin
          if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) nxt = pc + b_imm;
        end
        `OPC_JAL: begin
          we  = 1'b1;
          res = pc + 32'd4;
          nxt = pc + j_imm;
        end
        default: we = 1'b0;
      endcase
      if (w[11:7] == 5'd0) we = 1'b0;  // x0 stays zero
      if (we) regs[w[11:7]] = res;
      c.pc   = pc;
      c.rd   = w[11:7];
      c.we   = we;
      c.data = res;
      exp_q.push_back(c);
      pc = nxt;
      steps++;
      if (steps > MAX_RETIRE) fail_now("reference model never reached the end of the program");
    end
  endtask

  task automatic begin_run(input string name, input logic gaps);
    #1 rst_i = 1'b1;
    test_name = name;
    gaps_on   = gaps;
    run_reference();
    expected = exp_q.size();
    retired  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_i = 1'b0;
  endtask

  task automatic finish_run();
    int cycles;
    int limit;
    cycles = 0;
    limit  = expected * CYC_PER_COMMIT + 32;
    while (retired < expected) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_now($sformatf("%s: only %0d of %0d instructions retired in time",
                           test_name, retired, expected));
      end
    end
    repeat (DRAIN_CYCLES) @(posedge clk);  // any extra commit trips the monitor
  endtask

  task automatic build_alu_prog();
    prog_len = '0;
    add_instr(lui_word(5'd1, 20'h12345));
    add_instr(i_word(3'd0, 5'd1, 5'd1, 12'h678));
    add_instr(i_word(3'd0, 5'd2, 5'd0, 12'hffb));        // -5
    add_instr(r_word(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    add_instr(r_word(7'h20, 3'd0, 5'd4, 5'd3, 5'd1));    // sub
    add_instr(r_word(7'h00, 3'd2, 5'd5, 5'd4, 5'd0));    // slt negative
    add_instr(r_word(7'h00, 3'd2, 5'd6, 5'd0, 5'd4));
    add_instr(r_word(7'h00, 3'd4, 5'd7, 5'd5, 5'd3));
    add_instr(r_word(7'h00, 3'd6, 5'd8, 5'd7, 5'd2));
    add_instr(r_word(7'h00, 3'd7, 5'd9, 5'd8, 5'd1));
    add_instr(i_word(3'd7, 5'd10, 5'd9, 12'h0f0));
    add_instr(i_word(3'd6, 5'd11, 5'd10, 12'hf00));
    add_instr(i_word(3'd4, 5'd12, 5'd11, 12'h555));
    add_instr(r_word(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));    // write to x0
    add_instr(r_word(7'h00, 3'd0, 5'd13, 5'd0, 5'd12));
    add_instr(r_word(7'h20, 3'd0, 5'd14, 5'd13, 5'd13));
    add_instr(i_word(3'd0, 5'd15, 5'd14, 12'h001));
    add_instr(r_word(7'h00, 3'd0, 5'd16, 5'd15, 5'd13));
  endtask

  task automatic build_branch_prog();
    prog_len = '0;
    add_instr(i_word(3'd0, 5'd1, 5'd0, 12'd7));
    add_instr(i_word(3'd0, 5'd2, 5'd0, 12'd7));
    add_instr(i_word(3'd0, 5'd3, 5'd0, 12'd3));
    add_instr(branch_word(3'd0, 5'd1, 5'd2, 13'd12));   // beq taken
    add_instr(i_word(3'd0, 5'd4, 5'd0, 12'd1));
    add_instr(i_word(3'd0, 5'd4, 5'd0, 12'd2));
    add_instr(branch_word(3'd1, 5'd1, 5'd2, 13'd8));    // bne not taken
    add_instr(i_word(3'd0, 5'd5, 5'd0, 12'd5));
    add_instr(branch_word(3'd1, 5'd1, 5'd3, 13'd12));   // bne taken
    add_instr(i_word(3'd0, 5'd6, 5'd0, 12'd9));
    add_instr(i_word(3'd0, 5'd6, 5'd0, 12'd10));
    add_instr(branch_word(3'd0, 5'd1, 5'd3, 13'd8));    // beq not taken
    add_instr(i_word(3'd0, 5'd3, 5'd3, 12'd1));
    add_instr(branch_word(3'd1, 5'd3, 5'd1, 13'h1ffc)); // loop back until x3 == x1
    add_instr(r_word(7'h00, 3'd0, 5'd7, 5'd3, 5'd5));
  endtask

  task automatic build_jal_prog();
    prog_len = '0;
    add_instr(i_word(3'd0, 5'd1, 5'd0, 12'd1));
    add_instr(jal_word(5'd5, 21'd12));
    add_instr(i_word(3'd0, 5'd1, 5'd0, 12'd2));
    add_instr(i_word(3'd0, 5'd1, 5'd0, 12'd3));
    add_instr(r_word(7'h00, 3'd0, 5'd2, 5'd5, 5'd1));   // link used right away
    add_instr(jal_word(5'd0, 21'd12));                   // plain jump
    add_instr(i_word(3'd0, 5'd2, 5'd0, 12'd0));
    add_instr(i_word(3'd0, 5'd2, 5'd0, 12'd0));
    add_instr(i_word(3'd0, 5'd3, 5'd5, 12'd4));
    add_instr(jal_word(5'd6, 21'd8));
    add_instr(i_word(3'd0, 5'd3, 5'd0, 12'd0));
    add_instr(r_word(7'h00, 3'd0, 5'd4, 5'd6, 5'd3));
    add_instr(jal_word(5'd0, 21'd4));                    // jump to the next word
    add_instr(i_word(3'd0, 5'd7, 5'd4, 12'd1));
  endtask

  task automatic reset_state_test();
    build_alu_prog();
    begin_run("reset state", 1'b0);
    check_val("fetch address after reset", `RESET_PC, imem_addr_o);
    check_val("fetch request after reset", 32'd1, 32'(imem_req_o));
    check_val("commit valid after reset", 32'd0, 32'(commit_valid_o));
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_val("commit valid before first retire", 32'd0, 32'(commit_valid_o));
    end
    @(posedge clk);
    @(negedge clk);
    check_val("first retire valid", 32'd1, 32'(commit_valid_o));
    check_val("first retire pc", `RESET_PC, commit_pc_o);
    finish_run();
  endtask

  task automatic alu_chain_test(input logic gaps);
    build_alu_prog();
    begin_run(gaps ? "alu chain with fetch waits" : "alu chain", gaps);
    finish_run();
  endtask

  task automatic branch_test(input logic gaps);
    build_branch_prog();
    begin_run(gaps ? "branches with fetch waits" : "branches", gaps);
    finish_run();
  endtask

  task automatic jal_test(input logic gaps);
    build_jal_prog();
    begin_run(gaps ? "jal with fetch waits" : "jal", gaps);
    finish_run();
  endtask

  task automatic fetch_wait_test();
    alu_chain_test(1'b1);
    branch_test(1'b1);
    jal_test(1'b1);
  endtask

  initial begin
    gaps_on   = 1'b0;
    gap_ok    = 1'b1;
    prog_len  = '0;
    lfsr      = 32'he9b3_27a5;
    retired   = 0;
    expected  = 0;
    test_name = "startup";
    reset_state_test();
    alu_chain_test(1'b0);
    branch_test(1'b0);
    jal_test(1'b0);
    fetch_wait_test();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/rv_pipe_top.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module rv_pipe_top (
  input  wire                 clk,
  input  wire                 rst_i,
  // instruction memory
  output logic [`XLEN-1:0]    imem_addr_o,
  output logic                imem_req_o,
  input  wire [`XLEN-1:0]     imem_data_i,
  input  wire                 imem_valid_i,
  // retire port
  output logic                commit_valid_o,
  output logic [`XLEN-1:0]    commit_pc_o,
  output logic [`REG_AW-1:0]  commit_rd_o,
  output logic                commit_we_o,
  output logic [`XLEN-1:0]    commit_data_o
);
  import rv_pipe_pkg::*;

  pipe_ctrl_t         ctrl;
  redirect_t          redirect;
  if_id_t             if_id;
  id_ex_t             id_ex;
  ex_wb_t             ex_wb;
  logic [`REG_AW-1:0] rs1_idx;
  logic [`REG_AW-1:0] rs2_idx;
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst_i         (rst_i),
    .ctrl_i        (ctrl),
    .redirect_pc_i (redirect.pc),
    .imem_valid_i  (imem_valid_i),
    .imem_data_i   (imem_data_i),
    .imem_addr_o   (imem_addr_o),
    .imem_req_o    (imem_req_o),
    .if_id_o       (if_id)
  );

  decode_unit u_decode (
    .clk        (clk),
    .rst_i      (rst_i),
    .ctrl_i     (ctrl),
    .if_id_i    (if_id),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .id_ex_o    (id_ex)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (ex_wb)
  );

  execute_unit u_execute (
    .clk        (clk),
    .rst_i      (rst_i),
    .ctrl_i     (ctrl),
    .id_ex_i    (id_ex),
    .ex_wb_o    (ex_wb),
    .redirect_o (redirect)
  );

  hazard_ctrl u_hazard (
    .imem_valid_i (imem_valid_i),
    .redirect_i   (redirect),
    .ctrl_o       (ctrl)
  );

  // retire straight from the write-back register
  assign commit_valid_o = ex_wb.valid;
  assign commit_pc_o    = ex_wb.pc;
  assign commit_rd_o    = ex_wb.rd;
  assign commit_we_o    = ex_wb.we;
  assign commit_data_o  = ex_wb.result;

endmodule

`default_nettype wire

//--- hdl/hazard_ctrl.sv
`default_nettype none

module hazard_ctrl (
  input  wire                      imem_valid_i,
  input  rv_pipe_pkg::redirect_t   redirect_i,
  output rv_pipe_pkg::pipe_ctrl_t  ctrl_o
);
  import rv_pipe_pkg::*;

  logic fetch_wait;

  // a redirect discards the fetched word anyway, so it wins
  assign fetch_wait = !imem_valid_i && !redirect_i.valid;

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.pc_load   = redirect_i.valid;
    ctrl_o.id_flush  = redirect_i.valid;   // kill word in fetch
    ctrl_o.ex_flush  = redirect_i.valid;   // kill word in decode
    ctrl_o.pc_hold   = fetch_wait;
    ctrl_o.if_bubble = fetch_wait;
  end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module execute_unit (
  input  wire                     clk,
  input  wire                     rst_i,
  input  rv_pipe_pkg::pipe_ctrl_t ctrl_i,
  input  rv_pipe_pkg::id_ex_t     id_ex_i,
  output rv_pipe_pkg::ex_wb_t     ex_wb_o,
  output rv_pipe_pkg::redirect_t  redirect_o
);
  import rv_pipe_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic             fwd_ok;
  logic             taken;

  // bypass from the write-back register
  assign fwd_ok  = ex_wb_o.valid && ex_wb_o.we && (ex_wb_o.rd != '0);
  assign op_a    = (fwd_ok && ex_wb_o.rd == id_ex_i.rs1_idx) ? ex_wb_o.result
                                                             : id_ex_i.rs1_data;
  assign rs2_val = (fwd_ok && ex_wb_o.rd == id_ex_i.rs2_idx) ? ex_wb_o.result
                                                             : id_ex_i.rs2_data;
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;   // lui
      default:    alu_res = '0;
    endcase
  end

  // beq taken on equal, bne on not equal
  assign taken = id_ex_i.is_branch && ((op_a == rs2_val) ^ id_ex_i.br_ne);

  assign redirect_o.valid = id_ex_i.valid && (taken || id_ex_i.is_jal);
  assign redirect_o.pc    = id_ex_i.pc + id_ex_i.imm;

  always_ff @(posedge clk) begin
    ex_wb_o.pc     <= id_ex_i.pc;
    ex_wb_o.rd     <= id_ex_i.rd;
    ex_wb_o.we     <= id_ex_i.we;
    ex_wb_o.result <= id_ex_i.is_jal ? id_ex_i.pc + `XLEN'd4 : alu_res;
    ex_wb_o.valid  <= id_ex_i.valid;
    if (rst_i) ex_wb_o.valid <= 1'b0;
  end

  // a redirect kills both younger stages
  a_redirect_src: assert property (@(posedge clk) disable iff (rst_i)
    redirect_o.valid |-> ctrl_i.id_flush && ctrl_i.ex_flush);

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module decode_unit (
  input  wire                     clk,
  input  wire                     rst_i,
  input  rv_pipe_pkg::pipe_ctrl_t ctrl_i,
  input  rv_pipe_pkg::if_id_t     if_id_i,
  output logic [`REG_AW-1:0]      rs1_idx_o,
  output logic [`REG_AW-1:0]      rs2_idx_o,
  input  wire [`XLEN-1:0]         rs1_data_i,
  input  wire [`XLEN-1:0]         rs2_data_i,
  output rv_pipe_pkg::id_ex_t     id_ex_o
);
  import rv_pipe_pkg::*;

  instr_u ins;
  id_ex_t nxt;
  logic   wr;

  assign ins       = if_id_i.instr;
  assign rs1_idx_o = ins.r.rs1;
  assign rs2_idx_o = ins.r.rs2;

  always_comb begin
    nxt           = '0;
    nxt.valid     = if_id_i.valid;
    nxt.pc        = if_id_i.pc;
    nxt.rs1_idx   = ins.r.rs1;
    nxt.rs2_idx   = ins.r.rs2;
    nxt.rs1_data  = rs1_data_i;
    nxt.rs2_data  = rs2_data_i;
    nxt.rd        = ins.r.rd;
    nxt.imm       = {{(`XLEN-12){ins.i.imm[11]}}, ins.i.imm};
    nxt.alu_op    = ALU_ADD;
    wr            = 1'b0;

    case (ins.r.opcode)
      OP_REG: begin
        wr = 1'b1;
        case (ins.r.funct3)
          3'b000:  nxt.alu_op = ins.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010:  nxt.alu_op = ALU_SLT;
          3'b100:  nxt.alu_op = ALU_XOR;
          3'b110:  nxt.alu_op = ALU_OR;
          3'b111:  nxt.alu_op = ALU_AND;
          default: wr = 1'b0;   // shifts, sltu not supported
        endcase
      end
      OP_IMM: begin
        wr          = 1'b1;
        nxt.use_imm = 1'b1;
        case (ins.i.funct3)
          3'b000:  nxt.alu_op = ALU_ADD;
          3'b100:  nxt.alu_op = ALU_XOR;
          3'b110:  nxt.alu_op = ALU_OR;
          3'b111:  nxt.alu_op = ALU_AND;
          default: wr = 1'b0;
        endcase
      end
      OP_LUI: begin
        wr          = 1'b1;
        nxt.use_imm = 1'b1;
        nxt.alu_op  = ALU_PASS_B;
        nxt.imm     = {ins.j.imm20, ins.j.imm10_1, ins.j.imm11, ins.j.imm19_12, 12'b0};
      end
      OP_BRANCH: begin
        // only beq and bne, other compares retire as no-ops
        nxt.is_branch = (ins.b.funct3[2:1] == 2'b00);
        nxt.br_ne     = ins.b.funct3[0];
        nxt.imm       = {{(`XLEN-12){ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5,
                         ins.b.imm4_1, 1'b0};
      end
      OP_JAL: begin
        wr         = 1'b1;
        nxt.is_jal = 1'b1;
        nxt.imm    = {{(`XLEN-20){ins.j.imm20}}, ins.j.imm19_12, ins.j.imm11,
                      ins.j.imm10_1, 1'b0};
      end
      default: wr = 1'b0;   // unknown opcode, retire without write
    endcase

    nxt.we = wr && (ins.r.rd != '0);  // x0 never written
  end

  always_ff @(posedge clk) begin
    id_ex_o <= nxt;
    if (rst_i || ctrl_i.ex_flush) id_ex_o.valid <= 1'b0;
  end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module regfile (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire [`REG_AW-1:0]   rs1_idx_i,
  input  wire [`REG_AW-1:0]   rs2_idx_i,
  output logic [`XLEN-1:0]    rs1_data_o,
  output logic [`XLEN-1:0]    rs2_data_o,
  input  rv_pipe_pkg::ex_wb_t wb_i
);
  import rv_pipe_pkg::*;

  logic [`XLEN-1:0] regs [2**`REG_AW];
  logic             wr_en;

  assign wr_en = wb_i.valid && wb_i.we && (wb_i.rd != '0);  // x0 never written

  always_ff @(posedge clk) begin
    if (rst_i) begin
      regs[0] <= '0;
    end else if (wr_en) begin
      regs[wb_i.rd] <= wb_i.result;
    end
  end

  // write-through so decode sees the retiring result
  always_comb begin
    rs1_data_o = (wr_en && wb_i.rd == rs1_idx_i) ? wb_i.result : regs[rs1_idx_i];
    rs2_data_o = (wr_en && wb_i.rd == rs2_idx_i) ? wb_i.result : regs[rs2_idx_i];
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (rst_i)
    (rs1_idx_i == '0 |-> rs1_data_o == '0) and (rs2_idx_i == '0 |-> rs2_data_o == '0));

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none
`include "rv_pipe_macros.svh"

module fetch_unit (
  input  wire                     clk,
  input  wire                     rst_i,
  input  rv_pipe_pkg::pipe_ctrl_t ctrl_i,
  input  wire [`XLEN-1:0]         redirect_pc_i,
  input  wire                     imem_valid_i,
  input  wire [`XLEN-1:0]         imem_data_i,
  output logic [`XLEN-1:0]        imem_addr_o,
  output logic                    imem_req_o,
  output rv_pipe_pkg::if_id_t     if_id_o
);
  import rv_pipe_pkg::*;

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_d;
  logic             capture;

  always_comb begin
    if (ctrl_i.pc_load) begin
      pc_d = redirect_pc_i;
    end else if (ctrl_i.pc_hold) begin
      pc_d = pc_q;   // wait for the memory
    end else begin
      pc_d = pc_q + `XLEN'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign imem_addr_o = pc_q;
  assign imem_req_o  = !ctrl_i.pc_load;  // word at pc_q is dropped on redirect
  assign capture     = imem_valid_i && !(ctrl_i.if_bubble || ctrl_i.id_flush);

  always_ff @(posedge clk) begin
    if_id_o.pc    <= pc_q;
    if_id_o.instr <= capture ? imem_data_i : `NOP_INSTR;
    if_id_o.valid <= capture;
    if (rst_i) if_id_o.valid <= 1'b0;
  end

  // branch and jal targets must land on word boundaries
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/rv_pipe_pkg.sv
`default_nettype none
`include "rv_pipe_macros.svh"

package rv_pipe_pkg;

  typedef enum logic [6:0] {
    OP_REG    = `OPC_OP,
    OP_IMM    = `OPC_OP_IMM,
    OP_LUI    = `OPC_LUI,
    OP_BRANCH = `OPC_BRANCH,
    OP_JAL    = `OPC_JAL
  } opcode_e;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    opcode_e            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    opcode_e            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic               imm12;
    logic [5:0]         imm10_5;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm4_1;
    logic               imm11;
    opcode_e            opcode;
  } b_fmt_t;

  // upper 20 bits double as the lui immediate
  typedef struct packed {
    logic               imm20;
    logic [9:0]         imm10_1;
    logic               imm11;
    logic [7:0]         imm19_12;
    logic [`REG_AW-1:0] rd;
    opcode_e            opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    instr_u           instr;
  } if_id_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rs1_idx;
    logic [`REG_AW-1:0] rs2_idx;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   imm;
    alu_op_e            alu_op;
    logic               use_imm;
    logic               is_branch;
    logic               br_ne;     // bne when set, beq otherwise
    logic               is_jal;
    logic [`REG_AW-1:0] rd;
    logic               we;
  } id_ex_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic [`XLEN-1:0]   result;
  } ex_wb_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic pc_hold;
    logic pc_load;
    logic if_bubble;
    logic id_flush;
    logic ex_flush;
  } pipe_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/rv_pipe_macros.svh
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

// datapath and register index widths
`define XLEN     32
`define REG_AW   5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// addi x0, x0, 0
`define NOP_INSTR   32'h0000_0013

`endif
